//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := fetch_unit_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := TEST FAILED
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic                                              clock,
    input  logic                                              reset,
    input  fetch_pkg::addr_t    [fetch_pkg::fetch_width-1:0]  lookup_pc,
    output logic                [fetch_pkg::fetch_width-1:0]  taken,
    output fetch_pkg::counter_t [fetch_pkg::fetch_width-1:0]  counter,
    input  logic                                              update_valid,
    input  fetch_pkg::addr_t                                  update_pc,
    input  logic                                              update_taken
);

    import fetch_pkg::*;

    typedef logic [$clog2(bht_entries)-1:0] index_t;

    counter_t counters [bht_entries];
    index_t   update_index;
    counter_t update_value;

    // word aligned, so index starts above bit 2
    assign update_index = update_pc[2 +: $clog2(bht_entries)];
    assign update_value = counters[update_index];

    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            counter[i] = counters[index_t'(lookup_pc[i][2 +: $clog2(bht_entries)])];
            taken[i]   = counter[i][1];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < bht_entries; i++) begin
                counters[i] <= weakly_not_taken;
            end
        end else if (update_valid) begin
            if (update_taken) begin
                if (update_value != 2'b11) begin
                    counters[update_index] <= update_value + 2'd1;   // saturate at 3
                end
            end else if (update_value != 2'b00) begin
                counters[update_index] <= update_value - 2'd1;       // saturate at 0
            end
        end
    end

endmodule

//--- logic/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer (
    input  logic                                            clock,
    input  logic                                            reset,
    input  fetch_pkg::addr_t  [fetch_pkg::fetch_width-1:0]  lookup_pc,
    output logic              [fetch_pkg::fetch_width-1:0]  hit,
    output fetch_pkg::addr_t  [fetch_pkg::fetch_width-1:0]  target,
    input  logic                                            update_valid,
    input  fetch_pkg::addr_t                                update_pc,
    input  logic                                            update_taken,
    input  fetch_pkg::addr_t                                update_target
);

    import fetch_pkg::*;

    localparam int index_bits = $clog2(btb_entries);

    typedef logic [index_bits-1:0]                  index_t;
    typedef logic [$bits(addr_t)-index_bits-3:0]    tag_t;

    logic   valid   [btb_entries];
    tag_t   tags    [btb_entries];
    addr_t  targets [btb_entries];

    index_t update_index;
    tag_t   update_tag;

    assign update_index = update_pc[2 +: index_bits];
    assign update_tag   = update_pc[$bits(addr_t)-1 : index_bits+2];

    // every lane compares its own tag
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            hit[i] = valid[index_t'(lookup_pc[i][2 +: index_bits])]
                  && tags[index_t'(lookup_pc[i][2 +: index_bits])]
                     == lookup_pc[i][$bits(addr_t)-1 : index_bits+2];
            target[i] = targets[index_t'(lookup_pc[i][2 +: index_bits])];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < btb_entries; i++) begin
                valid[i] <= 1'b0;
            end
        end else if (update_valid && update_taken) begin
            valid[update_index] <= 1'b1;
        end
    end

    // tag and target storage
    always_ff @(posedge clock) begin
        if (update_valid && update_taken) begin
            tags[update_index]    <= update_tag;
            targets[update_index] <= update_target;
        end
    end

endmodule

//--- logic/fetch_pkg.sv
package fetch_pkg;

    // fetch group and buffer sizing
    localparam int fetch_width  = 4;
    localparam int count_bits   = 3;   // holds 0..fetch_width
    localparam int buffer_depth = 8;
    localparam int spots_bits   = 4;   // holds 0..buffer_depth

    // prediction tables
    localparam int bht_entries = 64;
    localparam int btb_entries = 16;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [1:0]  counter_t;   // msb set means taken

    localparam counter_t weakly_not_taken = 2'b01;

    // rv32 major opcodes that change control flow
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // one slot of the instruction buffer
    typedef struct packed {
        addr_t    pc;
        inst_t    inst;
        logic     predicted_taken;
        addr_t    predicted_pc;
        logic     is_jump;
        counter_t counter;
    } fetch_entry_t;

endpackage

//--- logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                                              clock,
    input  logic                                              reset,
    output fetch_pkg::addr_t    [fetch_pkg::fetch_width-1:0]  lane_pc,
    input  fetch_pkg::inst_t    [fetch_pkg::fetch_width-1:0]  cache_inst,
    input  logic                [fetch_pkg::fetch_width-1:0]  cache_miss,
    input  logic                [fetch_pkg::fetch_width-1:0]  pred_taken,
    input  fetch_pkg::counter_t [fetch_pkg::fetch_width-1:0]  pred_counter,
    input  logic                [fetch_pkg::fetch_width-1:0]  btb_hit,
    input  fetch_pkg::addr_t    [fetch_pkg::fetch_width-1:0]  btb_target,
    input  logic                [fetch_pkg::spots_bits-1:0]   free_spots,
    input  logic                                              restore_valid,
    input  fetch_pkg::addr_t                                  restore_pc,
    output logic                [fetch_pkg::count_bits-1:0]   enq_count,
    output fetch_pkg::addr_t    [fetch_pkg::fetch_width-1:0]  enq_pc,
    output fetch_pkg::inst_t    [fetch_pkg::fetch_width-1:0]  enq_inst,
    output logic                [fetch_pkg::fetch_width-1:0]  enq_predicted_taken,
    output fetch_pkg::addr_t    [fetch_pkg::fetch_width-1:0]  enq_predicted_pc,
    output logic                [fetch_pkg::fetch_width-1:0]  enq_is_jump,
    output fetch_pkg::counter_t [fetch_pkg::fetch_width-1:0]  enq_counter
);

    import fetch_pkg::*;

    addr_t                  pc_reg;
    addr_t                  next_pc;
    logic [fetch_width-1:0] is_branch;
    logic [fetch_width-1:0] is_jump;
    logic [fetch_width-1:0] redirect;
    logic [count_bits-1:0]  miss_limit;      // lanes before the first miss
    logic [count_bits-1:0]  redirect_limit;  // lanes up to and including first redirect
    logic [count_bits-1:0]  group_count;

    // lane pcs and opcode decode
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            lane_pc[i]   = pc_reg + addr_t'(4 * i);
            is_branch[i] = cache_inst[i][6:0] == op_branch;
            is_jump[i]   = cache_inst[i][6:0] == op_jal || cache_inst[i][6:0] == op_jalr;
            // without a btb hit there is no target to steer to
            redirect[i]  = ((is_branch[i] && pred_taken[i]) || is_jump[i]) && btb_hit[i];
        end
    end

    // lowest lane wins, so scan from the top down
    always_comb begin
        miss_limit     = count_bits'(fetch_width);
        redirect_limit = count_bits'(fetch_width);
        for (int i = fetch_width - 1; i >= 0; i--) begin
            if (cache_miss[i]) begin
                miss_limit = count_bits'(i);
            end
            if (redirect[i]) begin
                redirect_limit = count_bits'(i + 1);
            end
        end
    end

    assign group_count = (redirect_limit < miss_limit) ? redirect_limit : miss_limit;

    // never enqueue more than the buffer can take
    assign enq_count = (spots_bits'(group_count) > free_spots) ? count_bits'(free_spots)
                                                                : group_count;

    // entry fields for each lane
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            enq_pc[i]              = lane_pc[i];
            enq_inst[i]            = cache_inst[i];
            enq_predicted_taken[i] = redirect[i];
            enq_predicted_pc[i]    = redirect[i] ? btb_target[i] : lane_pc[i] + addr_t'(4);
            enq_is_jump[i]         = is_jump[i];
            enq_counter[i]         = pred_counter[i];
        end
    end

    // next pc follows the last kept lane
    always_comb begin
        next_pc = pc_reg + (addr_t'(enq_count) << 2);   // zero count holds the pc
        for (int i = 0; i < fetch_width; i++) begin
            if (enq_count == count_bits'(i + 1) && redirect[i]) begin
                next_pc = btb_target[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_reg <= '0;
        end else if (restore_valid) begin
            pc_reg <= restore_pc;   // resolution overrides the prediction
        end else begin
            pc_reg <= next_pc;
        end
    end

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic                                              clock,
    input  logic                                              reset,
    output fetch_pkg::addr_t    [fetch_pkg::fetch_width-1:0]  fetch_pc,
    input  fetch_pkg::inst_t    [fetch_pkg::fetch_width-1:0]  cache_inst,
    input  logic                [fetch_pkg::fetch_width-1:0]  cache_miss,
    input  logic                                              resolve_valid,
    input  fetch_pkg::addr_t                                  resolve_pc,
    input  logic                                              resolve_taken,
    input  fetch_pkg::addr_t                                  resolve_target,
    input  logic                                              restore_valid,
    input  fetch_pkg::addr_t                                  restore_pc,
    output logic                                              out_valid,
    output fetch_pkg::addr_t                                  out_pc,
    output fetch_pkg::inst_t                                  out_inst,
    output logic                                              out_predicted_taken,
    output fetch_pkg::addr_t                                  out_predicted_pc,
    output logic                                              out_is_jump,
    output fetch_pkg::counter_t                               out_counter
);

    import fetch_pkg::*;

    logic     [fetch_width-1:0] pred_taken;
    counter_t [fetch_width-1:0] pred_counter;
    logic     [fetch_width-1:0] btb_hit;
    addr_t    [fetch_width-1:0] btb_target;

    logic     [spots_bits-1:0]  free_spots;
    logic     [count_bits-1:0]  enq_count;
    addr_t    [fetch_width-1:0] enq_pc;
    inst_t    [fetch_width-1:0] enq_inst;
    logic     [fetch_width-1:0] enq_predicted_taken;
    addr_t    [fetch_width-1:0] enq_predicted_pc;
    logic     [fetch_width-1:0] enq_is_jump;
    counter_t [fetch_width-1:0] enq_counter;

    // lane pcs feed the cache, the predictor and the btb alike
    branch_predictor i_predictor (
        .clock        (clock),
        .reset        (reset),
        .lookup_pc    (fetch_pc),
        .taken        (pred_taken),
        .counter      (pred_counter),
        .update_valid (resolve_valid),
        .update_pc    (resolve_pc),
        .update_taken (resolve_taken)
    );

    branch_target_buffer i_btb (
        .clock         (clock),
        .reset         (reset),
        .lookup_pc     (fetch_pc),
        .hit           (btb_hit),
        .target        (btb_target),
        .update_valid  (resolve_valid),
        .update_pc     (resolve_pc),
        .update_taken  (resolve_taken),
        .update_target (resolve_target)
    );

    fetch_stage i_fetch (
        .clock               (clock),
        .reset               (reset),
        .lane_pc             (fetch_pc),
        .cache_inst          (cache_inst),
        .cache_miss          (cache_miss),
        .pred_taken          (pred_taken),
        .pred_counter        (pred_counter),
        .btb_hit             (btb_hit),
        .btb_target          (btb_target),
        .free_spots          (free_spots),
        .restore_valid       (restore_valid),
        .restore_pc          (restore_pc),
        .enq_count           (enq_count),
        .enq_pc              (enq_pc),
        .enq_inst            (enq_inst),
        .enq_predicted_taken (enq_predicted_taken),
        .enq_predicted_pc    (enq_predicted_pc),
        .enq_is_jump         (enq_is_jump),
        .enq_counter         (enq_counter)
    );

    inst_buffer i_buffer (
        .clock               (clock),
        .reset               (reset),
        .flush               (restore_valid),   // restore drops everything queued
        .enq_count           (enq_count),
        .enq_pc              (enq_pc),
        .enq_inst            (enq_inst),
        .enq_predicted_taken (enq_predicted_taken),
        .enq_predicted_pc    (enq_predicted_pc),
        .enq_is_jump         (enq_is_jump),
        .enq_counter         (enq_counter),
        .free_spots          (free_spots),
        .out_valid           (out_valid),
        .out_pc              (out_pc),
        .out_inst            (out_inst),
        .out_predicted_taken (out_predicted_taken),
        .out_predicted_pc    (out_predicted_pc),
        .out_is_jump         (out_is_jump),
        .out_counter         (out_counter)
    );

endmodule

//--- logic/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer (
    input  logic                                              clock,
    input  logic                                              reset,
    input  logic                                              flush,
    input  logic                [fetch_pkg::count_bits-1:0]   enq_count,
    input  fetch_pkg::addr_t    [fetch_pkg::fetch_width-1:0]  enq_pc,
    input  fetch_pkg::inst_t    [fetch_pkg::fetch_width-1:0]  enq_inst,
    input  logic                [fetch_pkg::fetch_width-1:0]  enq_predicted_taken,
    input  fetch_pkg::addr_t    [fetch_pkg::fetch_width-1:0]  enq_predicted_pc,
    input  logic                [fetch_pkg::fetch_width-1:0]  enq_is_jump,
    input  fetch_pkg::counter_t [fetch_pkg::fetch_width-1:0]  enq_counter,
    output logic                [fetch_pkg::spots_bits-1:0]   free_spots,
    output logic                                              out_valid,
    output fetch_pkg::addr_t                                  out_pc,
    output fetch_pkg::inst_t                                  out_inst,
    output logic                                              out_predicted_taken,
    output fetch_pkg::addr_t                                  out_predicted_pc,
    output logic                                              out_is_jump,
    output fetch_pkg::counter_t                               out_counter
);

    import fetch_pkg::*;

    typedef logic [$clog2(buffer_depth)-1:0] ptr_t;

    fetch_entry_t entries [buffer_depth];
    fetch_entry_t lane_entry [fetch_width];
    fetch_entry_t out_entry;

    ptr_t                   head;
    ptr_t                   tail;
    logic [spots_bits-1:0]  used;
    logic                   pop;
    logic                   bypass;   // lane 0 goes straight to the output when the queue is empty
    logic [count_bits-1:0]  stored;
    logic [fetch_width-1:0] write_en;
    ptr_t                   write_ptr [fetch_width];

    assign pop        = used != '0;
    assign bypass     = !pop && enq_count != '0;
    assign stored     = enq_count - count_bits'(bypass);
    assign free_spots = spots_bits'(buffer_depth) - used;

    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            lane_entry[i] = '{pc: enq_pc[i], inst: enq_inst[i],
                              predicted_taken: enq_predicted_taken[i],
                              predicted_pc: enq_predicted_pc[i],
                              is_jump: enq_is_jump[i], counter: enq_counter[i]};
            write_en[i]   = !flush && count_bits'(i) < enq_count && !(bypass && i == 0);
            write_ptr[i]  = tail + ptr_t'(i) - ptr_t'(bypass);
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head      <= '0;
            tail      <= '0;
            used      <= '0;
            out_valid <= 1'b0;
        end else begin
            head      <= head + ptr_t'(pop);
            tail      <= tail + ptr_t'(stored);
            used      <= used + spots_bits'(stored) - spots_bits'(pop);
            out_valid <= pop || bypass;
        end
    end

    // queue storage and the registered output payload
    always_ff @(posedge clock) begin
        for (int i = 0; i < fetch_width; i++) begin
            if (write_en[i]) begin
                entries[write_ptr[i]] <= lane_entry[i];
            end
        end
        if (pop) begin
            out_entry <= entries[head];
        end else if (bypass) begin
            out_entry <= lane_entry[0];
        end
    end

    assign out_pc              = out_entry.pc;
    assign out_inst            = out_entry.inst;
    assign out_predicted_taken = out_entry.predicted_taken;
    assign out_predicted_pc    = out_entry.predicted_pc;
    assign out_is_jump         = out_entry.is_jump;
    assign out_counter         = out_entry.counter;

endmodule

//--- tb.f
logic/fetch_pkg.sv
logic/branch_predictor.sv
logic/branch_target_buffer.sv
logic/fetch_stage.sv
logic/inst_buffer.sv
logic/fetch_unit.sv
verification/fetch_unit_asserts.sv
verification/fetch_unit_tb.sv

//--- verification/fetch_unit_asserts.sv
`timescale 1ns/1ps

module fetch_unit_asserts (
    input logic              clock,
    input logic              reset,
    input logic              restore_valid,
    input fetch_pkg::addr_t  restore_pc,
    input logic              out_valid,
    input fetch_pkg::addr_t  out_pc,
    input fetch_pkg::inst_t  out_inst,
    input logic              out_predicted_taken,
    input fetch_pkg::addr_t  out_predicted_pc,
    input logic              out_is_jump
);

    import fetch_pkg::*;

    logic  have_prev;           // an output seen since reset or the last restore
    addr_t prev_predicted_pc;
    logic  restore_pending;     // no output yet since the last restore
    addr_t restore_target;

    always_ff @(posedge clock) begin
        if (reset) begin
            have_prev         <= 1'b0;
            prev_predicted_pc <= '0;
            restore_pending   <= 1'b0;
            restore_target    <= '0;
        end else if (restore_valid) begin
            have_prev       <= 1'b0;
            restore_pending <= 1'b1;
            restore_target  <= restore_pc;
        end else if (out_valid) begin
            have_prev         <= 1'b1;
            prev_predicted_pc <= out_predicted_pc;
            restore_pending   <= 1'b0;
        end
    end

    a_reset_quiet: assert property (@(posedge clock) reset |=> !out_valid)
        else $error("out_valid high right after a reset cycle");

    a_restore_gap: assert property (@(posedge clock) disable iff (reset)
        restore_valid |=> !out_valid)
        else $error("output in the cycle right after a restore");

    // first instruction after a restore starts at the restore pc
    a_restore_first: assert property (@(posedge clock) disable iff (reset)
        out_valid && restore_pending |-> out_pc == restore_target)
        else $error("first output after restore is not at the restore pc");

    a_continuity: assert property (@(posedge clock) disable iff (reset)
        out_valid && have_prev |-> out_pc == prev_predicted_pc)
        else $error("output pc breaks the predicted stream");

    a_jump_flag: assert property (@(posedge clock) disable iff (reset)
        out_valid && (out_inst[6:0] == op_jal || out_inst[6:0] == op_jalr) |-> out_is_jump)
        else $error("jump instruction without the jump flag");

    a_fall_through: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_predicted_taken |-> out_predicted_pc == out_pc + 32'd4)
        else $error("not-taken entry does not predict the next word");

endmodule

bind fetch_unit fetch_unit_asserts i_asserts (
    .clock               (clock),
    .reset               (reset),
    .restore_valid       (restore_valid),
    .restore_pc          (restore_pc),
    .out_valid           (out_valid),
    .out_pc              (out_pc),
    .out_inst            (out_inst),
    .out_predicted_taken (out_predicted_taken),
    .out_predicted_pc    (out_predicted_pc),
    .out_is_jump         (out_is_jump)
);

//--- verification/fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam addr_t branch_pc  = 32'h0000_00c0;
    localparam addr_t branch_dst = 32'h0000_0300;
    localparam addr_t jump_pc    = 32'h0000_00e4;
    localparam addr_t jump_dst   = 32'h0000_0380;
    localparam addr_t far_pc     = 32'h0000_8000;   // never reached by straight-line fetch

    logic                    clock = 1'b0;
    logic                    reset;
    addr_t [fetch_width-1:0] fetch_pc;
    inst_t [fetch_width-1:0] cache_inst;
    logic  [fetch_width-1:0] cache_miss;
    logic                    resolve_valid;
    addr_t                   resolve_pc;
    logic                    resolve_taken;
    addr_t                   resolve_target;
    logic                    restore_valid;
    addr_t                   restore_pc;
    logic                    out_valid;
    addr_t                   out_pc;
    inst_t                   out_inst;
    logic                    out_predicted_taken;
    addr_t                   out_predicted_pc;
    logic                    out_is_jump;
    counter_t                out_counter;

    inst_t program_mem [256];
    logic  miss_active;
    addr_t miss_pc;
    logic  clean_fetch = 1'b0;   // miss_pc was fetched while not missing

    always #20 clock = ~clock;

    fetch_unit i_dut (
        .clock               (clock),
        .reset               (reset),
        .fetch_pc            (fetch_pc),
        .cache_inst          (cache_inst),
        .cache_miss          (cache_miss),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .restore_valid       (restore_valid),
        .restore_pc          (restore_pc),
        .out_valid           (out_valid),
        .out_pc              (out_pc),
        .out_inst            (out_inst),
        .out_predicted_taken (out_predicted_taken),
        .out_predicted_pc    (out_predicted_pc),
        .out_is_jump         (out_is_jump),
        .out_counter         (out_counter)
    );

    // cache model returns words from a 1 KB image repeating over the address space
    always_comb begin
        for (int i = 0; i < fetch_width; i++) begin
            cache_inst[i] = program_mem[fetch_pc[i][9:2]];
            cache_miss[i] = miss_active && fetch_pc[i] == miss_pc;
        end
    end

    // addi with every field taken from the word index
    function automatic inst_t fill_word(input logic [7:0] idx);
        return {4'h0, idx, idx[4:0], 3'b000, idx[7:3], 7'b0010011};
    endfunction

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        fail_run($sformatf("[ERROR] %0t: %s", $time, msg));
    endtask

    task automatic wait_for_output(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!out_valid && cycles < limit);
        if (!out_valid) begin
            fail_run("timeout: no instruction reached the output");
        end
    endtask

    task automatic wait_for_pc(input addr_t pc, input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!(out_valid && out_pc == pc) && cycles < limit);
        if (!(out_valid && out_pc == pc)) begin
            fail_run($sformatf("timeout: pc %h never reached the output", pc));
        end
    endtask

    task automatic train_taken(input addr_t pc, input addr_t target);
        @(posedge clock);
        #2;
        resolve_valid  = 1'b1;
        resolve_pc     = pc;
        resolve_taken  = 1'b1;
        resolve_target = target;
        @(posedge clock);
        #2;
        resolve_valid = 1'b0;
    endtask

    task automatic restore_to(input addr_t pc);
        @(posedge clock);
        #2;
        restore_valid = 1'b1;
        restore_pc    = pc;
        @(posedge clock);
        #2;
        restore_valid = 1'b0;
    endtask

    // output stream checks sampled mid-cycle
    always @(negedge clock) begin
        if (!reset) begin
            if (miss_active) begin
                clean_fetch <= 1'b0;
            end else begin
                for (int i = 0; i < fetch_width; i++) begin
                    if (fetch_pc[i] == miss_pc) clean_fetch <= 1'b1;
                end
            end
            if (out_valid) begin
                assert (out_inst == program_mem[out_pc[9:2]])
                    else report_mismatch($sformatf("inst %h at pc %h, expected %h",
                                         out_inst, out_pc, program_mem[out_pc[9:2]]));
                assert (out_pc != miss_pc || clean_fetch)
                    else report_mismatch($sformatf("pc %h out while its fetch missed", out_pc));
            end
        end
    end

    initial begin
        void'($urandom(96380));
        for (int i = 0; i < 256; i++) begin
            program_mem[i] = fill_word(8'(i));
        end
        program_mem[branch_pc[9:2]] = 32'h0020_8063;   // beq x1, x2
        program_mem[jump_pc[9:2]]   = 32'h0000_00ef;   // jal x1
        reset          = 1'b1;
        resolve_valid  = 1'b0;
        resolve_pc     = '0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        restore_valid  = 1'b0;
        restore_pc     = '0;
        miss_active    = 1'b0;
        miss_pc        = 32'hffff_fff0;
        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;

        // untrained counters sit at weakly not-taken
        wait_for_output(20);
        assert (out_pc == 32'h0 && out_counter == 2'b01)
            else report_mismatch($sformatf("first pc %h counter %b, expected 0 and 01",
                                 out_pc, out_counter));

        // miss stretches a few words ahead of the fetch pc
        repeat (4) begin
            @(posedge clock);
            #2;
            miss_pc     = fetch_pc[0] + addr_t'(4 * $urandom_range(4, 20));
            miss_active = 1'b1;
            repeat ($urandom_range(3, 24)) @(posedge clock);
            #2;
            miss_active = 1'b0;
            wait_for_pc(miss_pc, 200);
        end

        // nothing from before the flush may come out
        restore_to(far_pc);
        wait_for_output(20);
        assert (out_pc == far_pc)
            else report_mismatch($sformatf("restored pc %h, expected %h", out_pc, far_pc));
        for (int n = 0; n < 24; n++) begin
            @(negedge clock);
            assert (!out_valid || out_pc >= far_pc)
                else report_mismatch($sformatf("stale pc %h after restore", out_pc));
        end

        // two taken updates move the counter from 01 up to 11
        train_taken(branch_pc, branch_dst);
        train_taken(branch_pc, branch_dst);
        restore_to(branch_pc - 32'd16);
        wait_for_pc(branch_pc, 40);
        assert (out_predicted_taken && out_predicted_pc == branch_dst && out_counter == 2'b11)
            else report_mismatch($sformatf("branch predicted %b to %h counter %b",
                                 out_predicted_taken, out_predicted_pc, out_counter));
        wait_for_output(20);
        assert (out_pc == branch_dst)
            else report_mismatch($sformatf("pc %h after branch, expected %h", out_pc, branch_dst));

        // one taken update moves the jal counter from 01 to 10
        train_taken(jump_pc, jump_dst);
        restore_to(jump_pc - 32'd8);
        wait_for_pc(jump_pc, 40);
        assert (out_is_jump && out_predicted_taken && out_predicted_pc == jump_dst
                && out_counter == 2'b10)
            else report_mismatch($sformatf("jal flags %b %b target %h counter %b",
                                 out_is_jump, out_predicted_taken,
                                 out_predicted_pc, out_counter));
        wait_for_pc(jump_dst, 20);

        $display("TEST OK");
        $finish;
    end

endmodule
